// File: dv/osd_props.sv
// osd_props: bound assertions on sync pass-through, disabled pass-through and single-cycle writes
`timescale 1ns/1ns

module osd_props (
	input logic             clk_sys,
	input logic             ss,
	input osd_pkg::video_t  video_in,
	input osd_pkg::video_t  video_out,
	input logic             osd_enable,
	input osd_pkg::buf_wr_t buf_wr
);

	// ****************************************
	// video path
	// ****************************************

	// syncs are wired straight through
	sync_through: assert property (@(posedge clk_sys) disable iff (ss)
		(video_out.hs == video_in.hs) && (video_out.vs == video_in.vs))
		else $error("hs or vs on video_out differs from video_in");

	// overlay off means untouched video
	off_through: assert property (@(posedge clk_sys) disable iff (ss)
		!osd_enable |-> (video_out == video_in))
		else $error("video_out differs from video_in while the overlay is off");

	// ****************************************
	// host writes
	// ****************************************

	// one strobe per received byte, bytes are many clocks apart
	single_write: assert property (@(posedge clk_sys) disable iff (ss)
		buf_wr.valid |=> !buf_wr.valid)
		else $error("buffer write strobe high for two cycles in a row");

endmodule

bind osd_top osd_props u_props (
	.clk_sys    (clk_sys),
	.ss         (ss),
	.video_in   (video_in),
	.video_out  (video_out),
	.osd_enable (osd_enable),
	.buf_wr     (buf_wr)
);

// File: dv/osd_tb.sv
// osd_tb: clock, reset, serial host, two-mode video generator, reference model, pixel checker, watchdog
`timescale 1ns/1ns

module osd_tb;

	// ****************************************
	// timing of the stimulus
	// ****************************************

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	// host holds each sck phase this many clocks
	localparam int SCK_HALF = 4;

	// line: sync pulse first, then the picture
	localparam int H_SYNC = 40;
	localparam int H_VIS = 400;
	localparam int H_TOTAL = H_SYNC + H_VIS;
	// frame: sync lines first, then the picture
	localparam int V_SYNC = 4;
	localparam int V_VIS_A = 300;
	localparam int V_VIS_B = 400;

	localparam int WIN_W = int'(osd_pkg::OSD_WIDTH);
	localparam int WIN_H = int'(osd_pkg::OSD_HEIGHT);
	localparam int MAX_PRINT = 20;

	// run limit, every frame counted at the longer mode B length plus all host traffic
	localparam int FRAME_BUDGET = 26;
	localparam int FRAME_CYC_MAX = H_TOTAL * (V_SYNC + V_VIS_B);
	localparam int LINK_BYTES = 9 * 257 + 2;
	localparam int LINK_CYC = LINK_BYTES * 16 * SCK_HALF + 11 * 40;
	localparam longint WATCHDOG_NS =
		longint'(FRAME_BUDGET * FRAME_CYC_MAX + LINK_CYC) * CLK_PERIOD;

	// DUT inputs and output
	logic clk_sys = 1'b0;
	logic ss;
	logic ce_pix;
	logic sck;
	logic cs_n;
	logic sdi;
	osd_pkg::video_t video_in;
	osd_pkg::video_t video_out;

	// host side copy of the bitmap
	logic [7:0] shadow [osd_pkg::BUF_DEPTH];

	// generator state, mode B is the doublescan mode with active high syncs
	bit next_mode = 1'b0;
	bit cur_mode = 1'b0;
	int cur_x = 0;
	int cur_l = 0;
	int frame_cnt = 0;
	int frame_base = 0;

	// checker state
	bit check_on = 1'b0;
	bit exp_en = 1'b0;
	string test_name = "none";
	int errors = 0;
	int checked = 0;
	osd_pkg::video_t exp_out;

	osd_top dut (
		.clk_sys   (clk_sys),
		.ss        (ss),
		.ce_pix    (ce_pix),
		.sck       (sck),
		.cs_n      (cs_n),
		.sdi       (sdi),
		.video_in  (video_in),
		.video_out (video_out)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ****************************************
	// reference model
	// ****************************************

	// test picture, a gradient per channel moved by the frame base
	function automatic osd_pkg::rgb_t pixel_color(input int x, input int y, input int base);
		osd_pkg::rgb_t c;
		c.red = 6'(x + base);
		c.green = 6'(y ^ (base >> 6));
		c.blue = 6'(x + y + (base >> 12));
		return c;
	endfunction

	// expected rgb for one input sample, x and line count from the start of sync
	function automatic osd_pkg::rgb_t expected_pixel(input int x_tot, input int l_tot,
			input bit mode_b, input bit en, input osd_pkg::rgb_t pin);
		int x;
		int y;
		int meas_w;
		int meas_h;
		int half;
		int hs0;
		int vs0;
		int col;
		int vc;
		bit ds;
		logic [10:0] addr;
		logic [2:0] bsel;
		logic [7:0] byte_v;
		logic p;
		osd_pkg::rgb_t o;
		o = pin;
		if (!en || x_tot < H_SYNC || l_tot < V_SYNC) begin
			return o;
		end
		x = x_tot - H_SYNC;
		y = l_tot - V_SYNC;
		// sync edge to sync edge counts start at zero, one short of the visible size
		meas_w = H_VIS - 1;
		meas_h = (mode_b ? V_VIS_B : V_VIS_A) - 1;
		ds = meas_h > int'(osd_pkg::DOUBLESCAN_LINES);
		// doubled lines stretch the window to twice its height
		half = ds ? WIN_H : WIN_H / 2;
		hs0 = meas_w / 2 + int'(osd_pkg::OSD_X_OFFSET) - WIN_W / 2;
		vs0 = meas_h / 2 + int'(osd_pkg::OSD_Y_OFFSET) - half;
		// pixel count restarts one pixel into the picture and lags x by one
		if (x < hs0 + 1 || x > hs0 + WIN_W) begin
			return o;
		end
		// line count equals y on the picture lines
		if (y < vs0 || y > vs0 + 2 * half - 1) begin
			return o;
		end
		col = x - hs0 - 1;
		vc = y - vs0;
		// byte = 8 rows of one column, each row on 2 lines or 4 with doublescan
		if (ds) begin
			addr = 11'((vc / 32) * 256 + col);
			bsel = 3'((vc / 4) % 8);
		end else begin
			addr = 11'((vc / 16) * 256 + col);
			bsel = 3'((vc / 2) % 8);
		end
		byte_v = shadow[addr];
		p = byte_v[bsel];
		o.red = {p, p, osd_pkg::OSD_COLOR[2], pin.red[5:3]};
		o.green = {p, p, osd_pkg::OSD_COLOR[1], pin.green[5:3]};
		o.blue = {p, p, osd_pkg::OSD_COLOR[0], pin.blue[5:3]};
		return o;
	endfunction

	// ****************************************
	// video generator
	// ****************************************

	// mode is only switched at a frame start
	initial begin : video_gen
		int x_pos;
		int l_pos;
		int vis_l;
		bit sync_h;
		bit sync_v;
		x_pos = 0;
		l_pos = 0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (x_pos == 0 && l_pos == 0) begin
				cur_mode = next_mode;
				frame_base = $urandom;
				frame_cnt = frame_cnt + 1;
			end
			vis_l = cur_mode ? V_VIS_B : V_VIS_A;
			sync_h = x_pos < H_SYNC;
			sync_v = l_pos < V_SYNC;
			// mode A syncs active low, mode B active high
			video_in.hs = cur_mode ? sync_h : !sync_h;
			video_in.vs = cur_mode ? sync_v : !sync_v;
			if (sync_h || sync_v) begin
				video_in.rgb = '0;
			end else begin
				video_in.rgb = pixel_color(x_pos - H_SYNC, l_pos - V_SYNC, frame_base);
			end
			cur_x = x_pos;
			cur_l = l_pos;
			x_pos = x_pos + 1;
			if (x_pos == H_TOTAL) begin
				x_pos = 0;
				l_pos = l_pos + 1;
				if (l_pos == V_SYNC + vis_l) begin
					l_pos = 0;
				end
			end
		end
	end

	// ****************************************
	// pixel checker
	// ****************************************

	// output settles 1 ns after the rising edge, sampled mid cycle
	always @(negedge clk_sys) begin
		if (check_on) begin
			exp_out.rgb = expected_pixel(cur_x, cur_l, cur_mode, exp_en, video_in.rgb);
			exp_out.hs = video_in.hs;
			exp_out.vs = video_in.vs;
			checked = checked + 1;
			if (video_out !== exp_out) begin
				errors = errors + 1;
				if (errors <= MAX_PRINT) begin
					$display("error %s x=%0d line=%0d expected %h actual %h",
						test_name, cur_x, cur_l, exp_out, video_out);
				end
				if (errors == MAX_PRINT) begin
					$display("more mismatches are counted but not printed");
				end
			end
		end
	end

	// ****************************************
	// host link and sequencing tasks
	// ****************************************

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	// msb first, data set up in the low phase
	task automatic shift_byte(input logic [7:0] b);
		logic [7:0] sh;
		sh = b;
		repeat (8) begin
			sdi = sh[7];
			sh = {sh[6:0], 1'b0};
			sck = 1'b0;
			repeat (SCK_HALF) step();
			sck = 1'b1;
			repeat (SCK_HALF) step();
		end
	endtask

	task automatic begin_transfer();
		cs_n = 1'b0;
		repeat (SCK_HALF) step();
	endtask

	task automatic end_transfer();
		sck = 1'b0;
		repeat (SCK_HALF) step();
		cs_n = 1'b1;
		repeat (2 * SCK_HALF) step();
	endtask

	task automatic send_cmd(input logic [7:0] cmd);
		begin_transfer();
		shift_byte(cmd);
		end_transfer();
	endtask

	// fills one line group with random bytes, mirrored into the shadow
	task automatic write_group(input logic [2:0] grp);
		logic [7:0] d;
		logic [10:0] a;
		begin_transfer();
		shift_byte({osd_pkg::CMD_WRITE_OP, grp});
		for (int i = 0; i < 256; i++) begin
			d = 8'($urandom);
			a = {grp, 8'(i)};
			shadow[a] = d;
			shift_byte(d);
		end
		end_transfer();
	endtask

	// returns at the first sample of the n-th frame from now
	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		wait (frame_cnt >= target);
	endtask

	// checks exactly one frame, called at a frame start
	task automatic check_frame(input string name);
		test_name = name;
		check_on = 1'b1;
		wait_frames(1);
		check_on = 1'b0;
	endtask

	// ****************************************
	// test sequence
	// ****************************************

	initial begin : main_seq
		void'($urandom(13));
		ss = 1'b1;
		ce_pix = 1'b1;
		sck = 1'b0;
		cs_n = 1'b1;
		sdi = 1'b0;
		video_in = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		ss = 1'b0;

		// analyzer needs two full frames after reset
		wait_frames(3);
		check_frame("passthru_a");

		for (int g = 0; g < 8; g++) begin
			write_group(3'(g));
		end
		send_cmd(8'h41);
		exp_en = 1'b1;
		wait_frames(2);
		check_frame("overlay_a");

		// only window rows 48..63 change
		write_group(3'd3);
		wait_frames(2);
		check_frame("rewrite_a");

		// first mode B frame, then two for the new measurement
		next_mode = 1'b1;
		wait_frames(3);
		check_frame("doublescan_b");

		send_cmd(8'h40);
		exp_en = 1'b0;
		wait_frames(2);
		check_frame("disable_b");

		$display("errors: %0d, pixels checked: %0d", errors, checked);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// ****************************************
	// watchdog
	// ****************************************

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the OSD testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module osd_tb -Mdir "$OBJ" -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/Vosd_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "All tests passed!" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see $LOG"
exit 1

// File: verilog.f
verilog/osd_pkg.sv
verilog/osd_spi_slave.sv
verilog/osd_buffer.sv
verilog/video_timing_analyzer.sv
verilog/osd_mixer.sv
verilog/osd_top.sv
dv/osd_props.sv
dv/osd_tb.sv

// File: verilog/osd_buffer.sv
// osd_buffer: bitmap memory with a host write port and a pixel-enabled read port
`timescale 1ns/1ns

module osd_buffer (
	input  logic                       clk_sys,
	input  osd_pkg::buf_wr_t           buf_wr,
	input  logic                       ce_pix,
	input  logic [osd_pkg::BUF_AW-1:0] rd_addr,
	output logic [7:0]                 rd_data
);

	// ****************************************
	// bitmap storage
	// ****************************************

	// one byte holds 8 vertically stacked pixels of one column
	// addr[10:8] line group, addr[7:0] column
	logic [7:0] mem [osd_pkg::BUF_DEPTH];

	// host side
	always_ff @(posedge clk_sys) begin
		if (buf_wr.valid) begin
			mem[buf_wr.addr] <= buf_wr.data;
		end
	end

	// video side
	// one pixel of latency, the mixer asks one column ahead
	always_ff @(posedge clk_sys) begin
		if (ce_pix) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: verilog/osd_mixer.sv
// osd_mixer: bitmap read addressing, pixel select and overlay blend into the rgb stream
`timescale 1ns/1ns

module osd_mixer (
	input  logic                       clk_sys,
	input  logic                       ss,
	input  osd_pkg::osd_window_t       win,
	input  logic                       osd_enable,
	output logic [osd_pkg::BUF_AW-1:0] rd_addr,
	input  logic [7:0]                 rd_data,
	input  osd_pkg::video_t            video_in,
	output osd_pkg::video_t            video_out
);

	logic [2:0] grp;
	logic [2:0] row;
	logic [2:0] row_q;
	logic pix;
	logic show;
	osd_pkg::rgb_t blend;

	// ****************************************
	// buffer addressing
	// ****************************************

	// doublescan shows each bitmap row on four lines, else on two
	assign grp = win.doublescan ? win.vcnt[7:5] : win.vcnt[6:4];
	assign row = win.doublescan ? win.vcnt[4:2] : win.vcnt[3:1];
	assign rd_addr = {grp, win.hcnt[7:0]};

	// row index follows its byte through the read register
	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			row_q <= 3'd0;
		end else begin
			row_q <= row;
		end
	end

	assign pix = rd_data[row_q];

	// ****************************************
	// blend
	// ****************************************

	assign show = osd_enable & win.active;

	// pixel in the two msbs, tint next, dimmed input below
	always_comb begin
		blend.red = {pix, pix, osd_pkg::OSD_COLOR[2], video_in.rgb.red[5:3]};
		blend.green = {pix, pix, osd_pkg::OSD_COLOR[1], video_in.rgb.green[5:3]};
		blend.blue = {pix, pix, osd_pkg::OSD_COLOR[0], video_in.rgb.blue[5:3]};
	end

	// syncs never touched
	always_comb begin
		video_out.rgb = show ? blend : video_in.rgb;
		video_out.hs = video_in.hs;
		video_out.vs = video_in.vs;
	end

endmodule

// File: verilog/osd_pkg.sv
// osd_pkg: video, window, command and buffer-write types plus overlay geometry constants

package osd_pkg;

	// ****************************************
	// geometry
	// ****************************************

	// width of all timing counters
	localparam int CNT_W = 10;

	// overlay size in pixels and lines
	localparam logic [CNT_W-1:0] OSD_WIDTH = 10'd256;
	localparam logic [CNT_W-1:0] OSD_HEIGHT = 10'd128;

	// shift of the window away from the picture center
	localparam logic [CNT_W-1:0] OSD_X_OFFSET = 10'd0;
	localparam logic [CNT_W-1:0] OSD_Y_OFFSET = 10'd0;

	// tint bit per channel, red/green/blue from msb down
	localparam logic [2:0] OSD_COLOR = 3'd0;

	// bitmap memory, 8 line groups of 256 column bytes
	localparam int BUF_DEPTH = 2048;
	localparam int BUF_AW = 11;

	// taller pictures than this are treated as line doubled
	localparam logic [CNT_W-1:0] DOUBLESCAN_LINES = 10'd350;

	// ****************************************
	// host commands
	// ****************************************

	// 0x20..0x27 write line group
	localparam logic [4:0] CMD_WRITE_OP = 5'b00100;
	// 0x40 / 0x41 overlay off / on
	localparam logic [3:0] CMD_ENABLE_OP = 4'b0100;

	// ****************************************
	// types
	// ****************************************

	typedef struct packed {
		logic [5:0] red;
		logic [5:0] green;
		logic [5:0] blue;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic hs;
		logic vs;
	} video_t;

	// same command byte, read as a write or as an enable
	typedef union packed {
		struct packed {
			logic [4:0] op;
			logic [2:0] grp;
		} wr;
		struct packed {
			logic [3:0] op;
			logic [2:0] rsvd;
			logic on;
		} en;
	} osd_cmd_u;

	typedef struct packed {
		logic [BUF_AW-1:0] addr;
		logic [7:0] data;
		logic valid;
	} buf_wr_t;

	// hcnt runs one pixel ahead to cover the registered buffer read
	typedef struct packed {
		logic active;
		logic [CNT_W-1:0] hcnt;
		logic [CNT_W-1:0] vcnt;
		logic doublescan;
	} osd_window_t;

endpackage

// File: verilog/osd_spi_slave.sv
// osd_spi_slave: oversampled serial command link, byte assembly, command decode and bitmap writes
`timescale 1ns/1ns

module osd_spi_slave (
	input  logic             clk_sys,
	input  logic             ss,
	input  logic             sck,
	input  logic             cs_n,
	input  logic             sdi,
	output osd_pkg::buf_wr_t buf_wr,
	output logic             osd_enable
);

	// two-flop synchronizers, bit 1 is the clean copy
	logic [1:0] sck_sync;
	logic [1:0] cs_sync;
	logic [1:0] sdi_sync;
	logic sck_last;
	logic sck_rise;

	// byte assembly
	logic [6:0] sbuf;
	logic [7:0] rx_byte;
	logic [2:0] bit_cnt;
	logic have_cmd;

	// command state
	osd_pkg::osd_cmd_u rx_cmd;
	osd_pkg::osd_cmd_u cmd;
	logic write_mode;
	logic [osd_pkg::BUF_AW-1:0] wr_addr;

	// ****************************************
	// synchronizers
	// ****************************************

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			sck_sync <= 2'b00;
			// idle link is deselected
			cs_sync <= 2'b11;
			sdi_sync <= 2'b00;
			sck_last <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			cs_sync <= {cs_sync[0], cs_n};
			sdi_sync <= {sdi_sync[0], sdi};
			sck_last <= sck_sync[1];
		end
	end

	// sck edge only counts while selected
	assign sck_rise = sck_sync[1] & ~sck_last & ~cs_sync[1];

	// msb first, the newest bit lands in bit 0
	always_ff @(posedge clk_sys) begin
		if (sck_rise) begin
			sbuf <= {sbuf[5:0], sdi_sync[1]};
		end
	end

	assign rx_byte = {sbuf, sdi_sync[1]};
	assign rx_cmd = rx_byte;
	assign write_mode = have_cmd && (cmd.wr.op == osd_pkg::CMD_WRITE_OP);

	// ****************************************
	// command decode and buffer writes
	// ****************************************

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			bit_cnt <= 3'd0;
			have_cmd <= 1'b0;
			cmd <= '0;
			wr_addr <= '0;
			osd_enable <= 1'b0;
			buf_wr <= '0;
		end else begin
			// write strobe is a single cycle
			buf_wr.valid <= 1'b0;
			if (cs_sync[1]) begin
				// deselect ends the transfer
				bit_cnt <= 3'd0;
				have_cmd <= 1'b0;
				cmd <= '0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					if (!have_cmd) begin
						// first byte is the command
						have_cmd <= 1'b1;
						cmd <= rx_cmd;
						if (rx_cmd.en.op == osd_pkg::CMD_ENABLE_OP) begin
							osd_enable <= rx_cmd.en.on;
						end
						// line group selects a 256 byte slice
						wr_addr <= {rx_cmd.wr.grp, 8'h00};
					end else if (write_mode) begin
						buf_wr.valid <= 1'b1;
						buf_wr.addr <= wr_addr;
						buf_wr.data <= rx_byte;
						wr_addr <= wr_addr + 1'b1;
					end
				end
			end
		end
	end

endmodule

// File: verilog/osd_top.sv
// osd_top: on-screen display overlay top level, link, bitmap buffer, timing analyzer and mixer
`timescale 1ns/1ns

module osd_top (
	input  logic            clk_sys,
	input  logic            ss,
	input  logic            ce_pix,
	input  logic            sck,
	input  logic            cs_n,
	input  logic            sdi,
	input  osd_pkg::video_t video_in,
	output osd_pkg::video_t video_out
);

	osd_pkg::buf_wr_t buf_wr;
	logic osd_enable;
	osd_pkg::osd_window_t win;
	logic [osd_pkg::BUF_AW-1:0] rd_addr;
	logic [7:0] rd_data;

	// host link
	osd_spi_slave u_spi (
		.clk_sys    (clk_sys),
		.ss         (ss),
		.sck        (sck),
		.cs_n       (cs_n),
		.sdi        (sdi),
		.buf_wr     (buf_wr),
		.osd_enable (osd_enable)
	);

	osd_buffer u_buf (
		.clk_sys (clk_sys),
		.buf_wr  (buf_wr),
		.ce_pix  (ce_pix),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// window placement from measured sync timing
	video_timing_analyzer u_vta (
		.clk_sys  (clk_sys),
		.ss       (ss),
		.ce_pix   (ce_pix),
		.video_in (video_in),
		.win      (win)
	);

	osd_mixer u_mix (
		.clk_sys    (clk_sys),
		.ss         (ss),
		.win        (win),
		.osd_enable (osd_enable),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.video_in   (video_in),
		.video_out  (video_out)
	);

endmodule

// File: verilog/video_timing_analyzer.sv
// video_timing_analyzer: sync period and polarity measurement, centered overlay window, window counters
`timescale 1ns/1ns

module video_timing_analyzer (
	input  logic                 clk_sys,
	input  logic                 ss,
	input  logic                 ce_pix,
	input  osd_pkg::video_t      video_in,
	output osd_pkg::osd_window_t win
);

	localparam int W = osd_pkg::CNT_W;

	// horizontal measurement
	logic hs_d;
	logic [W-1:0] h_cnt;
	logic [W-1:0] hs_low;
	logic [W-1:0] hs_high;
	logic hs_pol;
	logic [W-1:0] h_width;
	logic [W-1:0] h_ctr;
	logic [W-1:0] h_start;
	logic [W-1:0] h_end;

	// vertical measurement, stepped per line
	logic hs_clk_d;
	logic hs_rise;
	logic vs_d;
	logic [W-1:0] v_cnt;
	logic [W-1:0] vs_low;
	logic [W-1:0] vs_high;
	logic vs_pol;
	logic [W-1:0] v_height;
	logic [W-1:0] v_ctr;
	logic [W-1:0] v_half;
	logic [W-1:0] v_start;
	logic [W-1:0] v_end;
	logic doublescan;

	// window state
	logic h_active;
	logic v_active;
	// vs edges seen, window trusted once both vs phases are measured
	logic [1:0] vs_edges;

	// ****************************************
	// line timing
	// ****************************************

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			hs_d <= 1'b0;
			h_cnt <= '0;
			hs_low <= '0;
			hs_high <= '0;
		end else if (ce_pix) begin
			hs_d <= video_in.hs;
			if (!video_in.hs && hs_d) begin
				// falling edge closes the high phase
				h_cnt <= '0;
				hs_high <= h_cnt;
			end else if (video_in.hs && !hs_d) begin
				// rising edge closes the low phase
				h_cnt <= '0;
				hs_low <= h_cnt;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// shorter phase is the pulse, the longer one the picture
	assign hs_pol = hs_high < hs_low;
	assign h_width = hs_pol ? hs_low : hs_high;
	assign h_ctr = {1'b0, h_width[W-1:1]};

	// ****************************************
	// frame timing
	// ****************************************

	assign hs_rise = video_in.hs & ~hs_clk_d;

	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			hs_clk_d <= 1'b0;
			vs_d <= 1'b0;
			v_cnt <= '0;
			vs_low <= '0;
			vs_high <= '0;
			vs_edges <= 2'd0;
		end else begin
			hs_clk_d <= video_in.hs;
			if (hs_rise) begin
				vs_d <= video_in.vs;
				if (video_in.vs != vs_d) begin
					v_cnt <= '0;
					if (video_in.vs) begin
						vs_low <= v_cnt;
					end else begin
						vs_high <= v_cnt;
					end
					if (vs_edges != 2'd3) begin
						vs_edges <= vs_edges + 2'd1;
					end
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end
		end
	end

	assign vs_pol = vs_high < vs_low;
	assign v_height = vs_pol ? vs_low : vs_high;
	assign v_ctr = {1'b0, v_height[W-1:1]};
	assign doublescan = v_height > osd_pkg::DOUBLESCAN_LINES;

	// ****************************************
	// centered window
	// ****************************************

	// line doubling stretches the window to twice its height
	assign v_half = doublescan ? osd_pkg::OSD_HEIGHT : (osd_pkg::OSD_HEIGHT >> 1);

	assign h_start = h_ctr + osd_pkg::OSD_X_OFFSET - (osd_pkg::OSD_WIDTH >> 1);
	assign h_end = h_ctr + osd_pkg::OSD_X_OFFSET + (osd_pkg::OSD_WIDTH >> 1) - 1'b1;
	assign v_start = v_ctr + osd_pkg::OSD_Y_OFFSET - v_half;
	assign v_end = v_ctr + osd_pkg::OSD_Y_OFFSET + v_half - 1'b1;

	// flags only move outside the sync pulses
	always_ff @(posedge clk_sys or posedge ss) begin
		if (ss) begin
			h_active <= 1'b0;
			v_active <= 1'b0;
		end else if (ce_pix) begin
			if (video_in.hs != hs_pol) begin
				// flag lags its count by a pixel, so it rises one count early
				if (h_cnt + 1'b1 == h_start) h_active <= 1'b1;
				if (h_cnt == h_end) h_active <= 1'b0;
			end
			if (video_in.vs != vs_pol) begin
				if (v_cnt == v_start) v_active <= 1'b1;
				// drops at the start of the first line below the window
				if (v_cnt == v_end + 1'b1) v_active <= 1'b0;
			end
		end
	end

	always_comb begin
		win.active = h_active & v_active & (vs_edges == 2'd3);
		// one column ahead for the buffer read register
		win.hcnt = h_cnt - h_start + 1'b1;
		win.vcnt = v_cnt - v_start;
		win.doublescan = doublescan;
	end

endmodule
